// ==== hw/particle_pkg.sv ====
package particle_pkg;

	// ========================================================================
	// Pixel level types
	// ========================================================================

	// Screen coordinate in pixels
	typedef logic [9:0] coord_t;
	// Velocity in pixels per frame step
	typedef logic signed [9:0] vel_t;
	// Linear frame buffer index
	typedef logic [18:0] pix_addr_t;
	// 8 bit RGB 3:3:2 colour
	typedef logic [7:0] color_t;

	// ========================================================================
	// Geometry and particle set
	// ========================================================================

	// Frame buffer row pitch
	localparam int SCREEN_WIDTH = 640;
	// Bounce limit on both axes
	localparam int BOX_SIZE = 200;
	localparam int NUM_PARTICLES = 4;

	// Start positions spread along a diagonal
	// x = 100 + 20*i
	localparam int START_X [NUM_PARTICLES] = '{100, 120, 140, 160};
	// y = 100 + 10*i
	localparam int START_Y [NUM_PARTICLES] = '{100, 110, 120, 130};

	// Even index moves down right, odd index moves down left
	localparam int START_VX [NUM_PARTICLES] = '{1, -1, 1, -1};
	localparam int START_VY [NUM_PARTICLES] = '{1, 1, 1, 1};

	// White, red, green, blue
	localparam color_t PARTICLE_COLOR [NUM_PARTICLES] = '{8'hFF, 8'hE0, 8'h1C, 8'h03};

	// Background is black
	localparam color_t ERASE_COLOR = 8'h00;

endpackage

// ==== hw/link_pkg.sv ====
package link_pkg;

	// ========================================================================
	// Pixel sink flow control
	// ========================================================================

	// Depth of the external write sink
	localparam int PIX_CREDITS = 4;

	// Holds 0 up to PIX_CREDITS
	typedef logic [2:0] credit_t;

	// Selects one of the particle engines
	typedef logic [1:0] idx_t;

	// ========================================================================
	// State machines
	// ========================================================================

	// Engine waits for advance, then erases, then draws
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_ERASE,
		ENG_DRAW
	} engine_state_e;

	// Writer idles between frames and scans engines during one
	typedef enum logic {
		WR_IDLE,
		WR_SCAN
	} writer_state_e;

endpackage

// ==== hw/pixel_req_if.sv ====
`timescale 1ns/1ps

// One engine's pixel request toward the writer
interface pixel_req_if;
	import particle_pkg::*;

	// Pixel is presented while req is high
	logic req;
	logic grant;
	coord_t x;
	coord_t y;
	color_t color;

	// Engine side
	// Holds req, x, y and color stable until grant
	modport source (
		output req, x, y, color,
		input  grant
	);

	// Writer side
	// Single cycle grant consumes the presented pixel
	modport sink (
		input  req, x, y, color,
		output grant
	);

endinterface

// ==== hw/step_sequencer.sv ====
`timescale 1ns/1ps

module step_sequencer (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic step,
	input  logic frame_end,
	output logic advance,
	output logic frame_busy
);

	// ========================================================================
	// Frame acceptance
	// ========================================================================

	// Step accepted only while no frame is in flight
	logic accept;

	assign accept = step && !frame_busy;

	// Busy from the cycle after acceptance
	// Cleared by the writer once the last draw is out
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			frame_busy <= 1'b0;
		end else if (accept) begin
			frame_busy <= 1'b1;
		end else if (frame_end) begin
			frame_busy <= 1'b0;
		end
	end

	// ========================================================================
	// Advance broadcast
	// ========================================================================

	// One cycle pulse to every engine and to the writer
	// Steps seen while busy are simply dropped
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			advance <= 1'b0;
		end else begin
			advance <= accept;
		end
	end

endmodule

// ==== hw/particle_engine.sv ====
`timescale 1ns/1ps

module particle_engine #(
	parameter int INDEX = 0
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic advance,
	pixel_req_if.source pix
);
	import particle_pkg::*;
	import link_pkg::*;

	// ========================================================================
	// Particle state
	// ========================================================================

	engine_state_e state;

	// Current position and velocity
	coord_t pos_x;
	coord_t pos_y;
	vel_t vel_x;
	vel_t vel_y;

	// Position drawn on the previous frame
	coord_t last_x;
	coord_t last_y;

	// Velocities after the bounce rule
	vel_t new_vx;
	vel_t new_vy;

	// Bounce rule for one axis
	// Reverse past the box edge or when the next step lands on zero
	function automatic vel_t bounce_vel(input coord_t pos, input vel_t vel);
		coord_t probe;
		// Wraps modulo 1024 like the coordinate itself
		probe = pos + coord_t'(vel);
		if ((pos > coord_t'(BOX_SIZE)) || (probe == '0)) begin
			return -vel;
		end
		return vel;
	endfunction

	assign new_vx = bounce_vel(pos_x, vel_x);
	assign new_vy = bounce_vel(pos_y, vel_y);

	// ========================================================================
	// Erase then draw sequence
	// ========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state <= ENG_IDLE;
			pos_x <= coord_t'(START_X[INDEX]);
			pos_y <= coord_t'(START_Y[INDEX]);
			vel_x <= vel_t'(START_VX[INDEX]);
			vel_y <= vel_t'(START_VY[INDEX]);
			// Nothing drawn yet so erase hits the start pixel
			last_x <= coord_t'(START_X[INDEX]);
			last_y <= coord_t'(START_Y[INDEX]);
		end else begin
			case (state)
				ENG_IDLE: begin
					if (advance) begin
						state <= ENG_ERASE;
					end
				end
				ENG_ERASE: begin
					if (pix.grant) begin
						state <= ENG_DRAW;
					end
				end
				ENG_DRAW: begin
					// Draw consumed, remember it and take one step
					if (pix.grant) begin
						state <= ENG_IDLE;
						last_x <= pos_x;
						last_y <= pos_y;
						vel_x <= new_vx;
						vel_y <= new_vy;
						pos_x <= pos_x + coord_t'(new_vx);
						pos_y <= pos_y + coord_t'(new_vy);
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// ========================================================================
	// Request outputs
	// ========================================================================

	// Request follows state so it rises the cycle after advance
	always_comb begin
		pix.req = (state != ENG_IDLE);
		if (state == ENG_ERASE) begin
			pix.x = last_x;
			pix.y = last_y;
			pix.color = ERASE_COLOR;
		end else begin
			pix.x = pos_x;
			pix.y = pos_y;
			pix.color = PARTICLE_COLOR[INDEX];
		end
	end

endmodule

// ==== hw/pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic frame_start,
	pixel_req_if.sink pix [particle_pkg::NUM_PARTICLES-1:0],
	input  logic pix_credit,
	output logic pix_valid,
	output particle_pkg::pix_addr_t pix_addr,
	output particle_pkg::color_t pix_color,
	output logic frame_end
);
	import particle_pkg::*;
	import link_pkg::*;

	// ========================================================================
	// Request gathering
	// ========================================================================

	writer_state_e state;
	idx_t cur_idx;
	// High once the current engine's erase is granted
	logic draw_phase;
	credit_t credits;

	logic [NUM_PARTICLES-1:0] req_vec;
	logic [NUM_PARTICLES-1:0] grant_vec;
	coord_t x_vec [NUM_PARTICLES];
	coord_t y_vec [NUM_PARTICLES];
	color_t color_vec [NUM_PARTICLES];

	logic grant_any;
	logic last_grant;
	pix_addr_t sel_addr;

	// Flatten the interface array so it can be indexed by cur_idx
	for (genvar g = 0; g < NUM_PARTICLES; g++) begin : g_port
		assign req_vec[g] = pix[g].req;
		assign x_vec[g] = pix[g].x;
		assign y_vec[g] = pix[g].y;
		assign color_vec[g] = pix[g].color;
		assign pix[g].grant = grant_vec[g];
	end

	// Grant only the scanned engine and only with credit left
	always_comb begin
		grant_vec = '0;
		if ((state == WR_SCAN) && (credits != '0)) begin
			grant_vec[cur_idx] = req_vec[cur_idx];
		end
	end

	assign grant_any = |grant_vec;
	// Draw of the highest index closes the frame
	assign last_grant = grant_any && draw_phase && (cur_idx == idx_t'(NUM_PARTICLES - 1));

	// Row major address
	assign sel_addr = pix_addr_t'(y_vec[cur_idx]) * pix_addr_t'(SCREEN_WIDTH)
		+ pix_addr_t'(x_vec[cur_idx]);

	// ========================================================================
	// Scan FSM
	// ========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state <= WR_IDLE;
			cur_idx <= '0;
			draw_phase <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (frame_start) begin
						state <= WR_SCAN;
						cur_idx <= '0;
						draw_phase <= 1'b0;
					end
				end
				WR_SCAN: begin
					if (grant_any && !draw_phase) begin
						draw_phase <= 1'b1;
					end else if (grant_any) begin
						// Second grant so move on
						draw_phase <= 1'b0;
						if (last_grant) begin
							state <= WR_IDLE;
						end else begin
							cur_idx <= cur_idx + idx_t'(1);
						end
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// ========================================================================
	// Credits and output register
	// ========================================================================

	// Spend on grant, refill on pix_credit
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			credits <= credit_t'(PIX_CREDITS);
		end else begin
			case ({grant_any, pix_credit})
				2'b10: credits <= credits - credit_t'(1);
				2'b01: credits <= credits + credit_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Write appears one cycle after its grant
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			pix_valid <= grant_any;
			frame_end <= last_grant;
		end
	end

	// Payload only
	always_ff @(posedge CLOCK_50) begin
		if (grant_any) begin
			pix_addr <= sel_addr;
			pix_color <= color_vec[cur_idx];
		end
	end

endmodule

// ==== hw/particle_display.sv ====
`timescale 1ns/1ps

module particle_display (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic step,
	input  logic pix_credit,
	output logic pix_valid,
	output particle_pkg::pix_addr_t pix_addr,
	output particle_pkg::color_t pix_color,
	output logic frame_busy
);
	import particle_pkg::*;

	// ========================================================================
	// Internal wiring
	// ========================================================================

	// Frame kick to engines and writer
	logic advance;
	// Writer reports last draw granted
	logic frame_end;

	// One request channel per particle
	pixel_req_if pix_if [NUM_PARTICLES-1:0] ();

	// Step gating and busy flag
	step_sequencer seq0 (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.step       (step),
		.frame_end  (frame_end),
		.advance    (advance),
		.frame_busy (frame_busy)
	);

	// Particle engines
	for (genvar g = 0; g < NUM_PARTICLES; g++) begin : g_engine
		particle_engine #(
			.INDEX (g)
		) engine0 (
			.CLOCK_50 (CLOCK_50),
			.rst_n    (rst_n),
			.advance  (advance),
			.pix      (pix_if[g])
		);
	end

	// Arbitration and credit handling toward the frame buffer
	pixel_writer writer0 (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.frame_start (advance),
		.pix         (pix_if),
		.pix_credit  (pix_credit),
		.pix_valid   (pix_valid),
		.pix_addr    (pix_addr),
		.pix_color   (pix_color),
		.frame_end   (frame_end)
	);

endmodule

// ==== test/particle_display_checker.sv ====
`timescale 1ns/1ps

module particle_display_checker (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [particle_pkg::NUM_PARTICLES-1:0] grant_vec,
	input link_pkg::credit_t credits,
	input logic pix_valid
);
	import link_pkg::*;

	// ========================================================================
	// Credit rules
	// ========================================================================

	// Grant spends a credit so one must be left
	credit_needed: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(|grant_vec) |-> (credits != '0))
		else $error("writer granted with zero credits");

	// Returns never push the count above the sink depth
	credit_bound: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		credits <= credit_t'(PIX_CREDITS))
		else $error("credit count above the sink depth");

	// ========================================================================
	// Grant rules
	// ========================================================================

	// Single engine served per cycle
	one_grant: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$onehot0(grant_vec))
		else $error("more than one grant in a cycle");

	// Registered write one cycle behind its grant
	valid_after_grant: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(|grant_vec) |=> pix_valid)
		else $error("grant not followed by a write");

endmodule

// Attach to every writer instance
bind pixel_writer particle_display_checker chk0 (
	.CLOCK_50  (CLOCK_50),
	.rst_n     (rst_n),
	.grant_vec (grant_vec),
	.credits   (credits),
	.pix_valid (pix_valid)
);

// ==== test/tb_particle_display.sv ====
`timescale 1ns/1ps

module tb_particle_display;
	import particle_pkg::*;
	import link_pkg::*;

	// ========================================================================
	// Limits and trace layout
	// ========================================================================

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_WRITES = 2 * NUM_PARTICLES;
	// Longest wait allowed for any handshake
	localparam int WAIT_LIMIT = 2000;
	// Idle cycles watched for stray writes
	localparam int QUIET_CYCLES = 20;
	// Three words per trace record
	localparam int TRACE_WORDS = 96;
	localparam int OP_END = 0;
	localparam int OP_FRAME = 1;
	localparam int OP_WRITE = 2;
	localparam int OP_SKIP = 3;

	logic CLOCK_50;
	logic rst_n;
	logic step;
	logic pix_credit;
	logic pix_valid;
	pix_addr_t pix_addr;
	color_t pix_color;
	logic frame_busy;

	logic [19:0] trace_mem [TRACE_WORDS];
	pix_addr_t exp_addr [$];
	color_t exp_color [$];
	logic [31:0] lfsr;
	// Sink side view of the credit loop
	logic credit_hold;
	int outstanding;
	int frame_writes;
	int value_errors;
	int other_errors;
	logic timed_out;
	int ptr;

	particle_display dut0 (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.step       (step),
		.pix_credit (pix_credit),
		.pix_valid  (pix_valid),
		.pix_addr   (pix_addr),
		.pix_color  (pix_color),
		.frame_busy (frame_busy)
	);

	always #(CLK_HALF) CLOCK_50 = ~CLOCK_50;

	// ========================================================================
	// Sink model
	// ========================================================================

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One cycle, sampled at the falling edge where outputs are settled
	task automatic tick();
		@(negedge CLOCK_50);
		if (pix_valid === 1'b1) begin
			frame_writes++;
			outstanding++;
			if (exp_addr.size() != 0) begin
				if (pix_addr !== exp_addr[0]) begin
					value_errors++;
					$display("Error: pix_addr got %h expected %h", pix_addr, exp_addr[0]);
				end
				if (pix_color !== exp_color[0]) begin
					value_errors++;
					$display("Error: pix_color got %h expected %h", pix_color, exp_color[0]);
				end
				void'(exp_addr.pop_front());
				void'(exp_color.pop_front());
			end
		end
		// Random return, only for writes the sink still holds
		pix_credit = 1'b0;
		if (!credit_hold && (outstanding > 0)) begin
			if (lfsr[0]) begin
				pix_credit = 1'b1;
				outstanding--;
			end
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Loop until the frame has seen target writes
	task automatic wait_writes(input int target);
		int waited;
		waited = 0;
		while ((frame_writes < target) && (waited < WAIT_LIMIT)) begin
			tick();
			waited++;
		end
		if (frame_writes < target) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout with only %0d of %0d writes seen", frame_writes, target);
		end
	endtask

	// Watch a stretch of cycles in which no write may appear
	task automatic check_quiet(input int expected, input string what);
		repeat (QUIET_CYCLES) begin
			tick();
		end
		if (frame_writes != expected) begin
			other_errors++;
			$display("%0d writes seen where %0d were allowed %s", frame_writes, expected, what);
		end
	endtask

	// ========================================================================
	// Frame sequence
	// ========================================================================

	// Pixel writes that follow a frame record in the trace
	task automatic load_expected(input int base);
		exp_addr.delete();
		exp_color.delete();
		for (int k = 0; k < FRAME_WRITES; k++) begin
			if (int'(trace_mem[base + 3 * k]) != OP_WRITE) begin
				other_errors++;
				$display("Trace frame record lacks one of its pixel writes");
			end
			exp_addr.push_back(pix_addr_t'(trace_mem[base + 3 * k + 1]));
			exp_color.push_back(color_t'(trace_mem[base + 3 * k + 2]));
		end
	endtask

	// Mode bit 0 holds credits back, bit 1 steps again while busy
	task automatic run_frame(input int mode);
		int stall_at;
		stall_at = PIX_CREDITS - outstanding;
		frame_writes = 0;
		credit_hold = mode[0];
		step = 1'b1;
		tick();
		step = 1'b0;
		if (frame_busy !== 1'b1) begin
			other_errors++;
			$display("Error: frame_busy got %h expected 1 after an accepted step", frame_busy);
		end
		if (mode[0]) begin
			wait_writes(stall_at);
			if (timed_out) begin
				return;
			end
			check_quiet(stall_at, "with no credit returned");
			credit_hold = 1'b0;
		end
		wait_writes(FRAME_WRITES);
		if (timed_out) begin
			return;
		end
		// Last write of the frame is on this cycle
		if (frame_busy !== 1'b1) begin
			other_errors++;
			$display("Error: frame_busy got %h expected 1 at the last write", frame_busy);
		end
		// Extra step while still busy but with the engines idle again
		step = mode[1];
		tick();
		step = 1'b0;
		if (frame_busy !== 1'b0) begin
			other_errors++;
			$display("Error: frame_busy got %h expected 0 after the last write", frame_busy);
		end
		check_quiet(FRAME_WRITES, "after the frame ended");
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		CLOCK_50 = 1'b0;
		rst_n = 1'b0;
		step = 1'b0;
		pix_credit = 1'b0;
		lfsr = 32'h13a4;
		credit_hold = 1'b0;
		outstanding = 0;
		frame_writes = 0;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		ptr = 0;
		for (int i = 0; i < TRACE_WORDS; i++) begin
			trace_mem[i] = '0;
		end
		$readmemh("test/particle_trace.txt", trace_mem);

		repeat (RESET_CYCLES) begin
			tick();
		end
		rst_n = 1'b1;
		tick();
		if ((pix_valid !== 1'b0) || (frame_busy !== 1'b0)) begin
			other_errors++;
			$display("Error: pix_valid got %h frame_busy got %h expected 0 after reset",
				pix_valid, frame_busy);
		end

		// Walk the trace until its end record
		while (!timed_out && (ptr + 3 <= TRACE_WORDS)) begin
			case (int'(trace_mem[ptr]))
				OP_FRAME: begin
					load_expected(ptr + 3);
					run_frame(int'(trace_mem[ptr + 1]));
					ptr = ptr + 3 * (FRAME_WRITES + 1);
				end
				OP_SKIP: begin
					exp_addr.delete();
					exp_color.delete();
					for (int n = 0; (n < int'(trace_mem[ptr + 1])) && !timed_out; n++) begin
						run_frame(0);
					end
					ptr = ptr + 3;
				end
				OP_END: ptr = TRACE_WORDS;
				default: begin
					other_errors++;
					$display("Unknown trace record %h", trace_mem[ptr]);
					ptr = TRACE_WORDS;
				end
			endcase
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0)) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== test/particle_trace.txt ====
// op a b in hex. 1 = frame step with mode a (bit0 credit hold, bit1 extra step)
// 2 = expected write of address a and colour b, 3 = a unchecked frames, 0 = end
1 3 0
2 0FA64 00
2 0FA64 FF
2 11378 00
2 11378 E0
2 12C8C 00
2 12C8C 1C
2 145A0 00
2 145A0 03
3 77 0
1 0 0
2 1CA37 00
2 1C7B6 FF
2 1B081 00
2 1AE02 E0
2 1980F 00
2 1958E 1C
2 17EA9 00
2 17C28 03
0 0 0

// ==== src.f ====
hw/particle_pkg.sv
hw/link_pkg.sv
hw/pixel_req_if.sv
hw/step_sequencer.sv
hw/particle_engine.sv
hw/pixel_writer.sv
hw/particle_display.sv
test/particle_display_checker.sv
test/tb_particle_display.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps --top-module tb_particle_display \
	-f src.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
